//--- design/eth_mac_pkg.sv
package eth_mac_pkg;

	////////////////////////////////////////
	// Data types

	// One GMII data byte
	typedef logic [7:0] gmii_byte_t;

	// Valid bytes in an upper layer word, 1 to 4
	typedef logic [2:0] bytes_valid_t;

	// Receive FSM states
	// CRC control in the framer decodes these too
	typedef enum logic [2:0] {
		RX_IDLE       = 3'd0,
		RX_PREAMBLE   = 3'd1,
		RX_FRAME_DATA = 3'd2,
		RX_CHECK      = 3'd3,
		RX_DROP       = 3'd4
	} rx_state_t;

	////////////////////////////////////////
	// Framing constants

	// Preamble filler
	localparam gmii_byte_t ETH_PREAMBLE_BYTE = 8'h55;

	// Start of frame delimiter
	localparam gmii_byte_t ETH_SFD_BYTE = 8'hd5;

	////////////////////////////////////////
	// CRC-32 constants

	// Reflected form of 0x04C11DB7
	localparam logic [31:0] CRC32_POLY = 32'hedb88320;

	// Register preset
	localparam logic [31:0] CRC32_INIT = 32'hffffffff;

	// Register value left over once a good FCS has gone through
	localparam logic [31:0] CRC32_RESIDUE = 32'hdebb20e3;

endpackage

//--- design/crc32_eth.sv
`timescale 1ns/100ps

module crc32_eth import eth_mac_pkg::*; (
	input  logic        gmii_rx_clk,
	input  logic        arst_n,
	input  logic        crc_restart,
	input  logic        crc_update,
	input  gmii_byte_t  din,
	output logic [31:0] crc
);

	////////////////////////////////////////
	// Byte step

	// Shift eight bits through the reflected polynomial, LSB first
	function automatic logic [31:0] crc_next(input logic [31:0] cur, input gmii_byte_t b);
		logic [31:0] r;
		r = cur ^ {24'h0, b};
		for (int i = 0; i < 8; i++) begin
			if (r[0])
				r = (r >> 1) ^ CRC32_POLY;
			else
				r = r >> 1;
		end
		return r;
	endfunction

	////////////////////////////////////////
	// CRC register

	logic [31:0] crc_reg;

	always_ff @(posedge gmii_rx_clk or negedge arst_n) begin
		if (!arst_n) begin
			crc_reg <= CRC32_INIT;
		end else begin
			// Restart wins over an update on the same clock
			if (crc_restart)
				crc_reg <= CRC32_INIT;
			else if (crc_update)
				crc_reg <= crc_next(crc_reg, din);
		end
	end

	// Raw register out
	// No final inversion, the framer compares against the residue
	assign crc = crc_reg;

endmodule

//--- design/gmii_rx_framer.sv
`timescale 1ns/100ps

module gmii_rx_framer import eth_mac_pkg::*; (
	input  logic         gmii_rx_clk,
	input  logic         arst_n,

	// GMII receive side
	input  logic         dvalid,
	input  logic         en,
	input  logic         er,
	input  gmii_byte_t   data,
	input  logic         link_up,

	// CRC engine
	input  logic [31:0]  crc,
	output logic         crc_restart,
	output logic         crc_update,
	output gmii_byte_t   crc_din,

	// Upper layer
	output logic         start,
	output logic         data_valid,
	output logic [31:0]  word_data,
	output bytes_valid_t bytes_valid,
	output logic         commit,
	output logic         drop
);

	////////////////////////////////////////
	// State and datapath registers

	rx_state_t   state;

	// Last four frame bytes, newest in the low byte
	// These may turn out to be the FCS so they are held back
	logic [31:0] hold;
	logic [2:0]  hold_cnt;

	// Bytes released from the hold-back, waiting for a full word
	logic [23:0] pack;
	logic [1:0]  pack_cnt;

	// er seen on a frame data byte
	logic        frame_err;

	logic        hold_full;
	gmii_byte_t  out_byte;
	logic        crc_ok;

	// Hold-back is full once four bytes have arrived
	assign hold_full = (hold_cnt == 3'd4);

	// Byte pushed out of the hold-back by the next accepted byte
	assign out_byte = hold[31:24];

	// Good FCS leaves the fixed residue in the register
	assign crc_ok = (crc == CRC32_RESIDUE);

	////////////////////////////////////////
	// CRC control

	// Preset all through the preamble, so the engine is fresh at the SFD
	assign crc_restart = (state == RX_PREAMBLE);

	// Every accepted frame byte goes in, FCS included
	assign crc_update = (state == RX_FRAME_DATA) && dvalid && en && link_up;
	assign crc_din    = data;

	////////////////////////////////////////
	// Receive FSM

	always_ff @(posedge gmii_rx_clk or negedge arst_n) begin
		if (!arst_n) begin
			state      <= RX_IDLE;
			start      <= 1'b0;
			data_valid <= 1'b0;
			commit     <= 1'b0;
			drop       <= 1'b0;
			hold_cnt   <= 3'd0;
			pack_cnt   <= 2'd0;
			frame_err  <= 1'b0;
		end else begin
			// Pulses by default
			start      <= 1'b0;
			data_valid <= 1'b0;
			commit     <= 1'b0;
			drop       <= 1'b0;

			case (state)

				// Wait for a frame while the link is up
				// er outside a frame is of no interest
				RX_IDLE: begin
					if (dvalid && en && link_up) begin
						if (data == ETH_PREAMBLE_BYTE && !er)
							state <= RX_PREAMBLE;
						else
							state <= RX_DROP;
					end
				end

				// Preamble bytes until the SFD
				// Nothing announced yet, so failures here stay silent
				RX_PREAMBLE: begin
					if (!link_up) begin
						state <= RX_IDLE;
					end else if (dvalid) begin
						if (!en) begin
							// Truncated preamble
							state <= RX_IDLE;
						end else if (er) begin
							state <= RX_DROP;
						end else if (data == ETH_SFD_BYTE) begin
							start     <= 1'b1;
							hold_cnt  <= 3'd0;
							pack_cnt  <= 2'd0;
							frame_err <= 1'b0;
							state     <= RX_FRAME_DATA;
						end else if (data != ETH_PREAMBLE_BYTE) begin
							// Junk before the SFD, skip the rest of it
							state <= RX_DROP;
						end
					end
				end

				// Frame body, FCS at the tail
				RX_FRAME_DATA: begin
					if (!link_up) begin
						// Link lost after start, close the frame with a drop
						drop  <= 1'b1;
						state <= RX_IDLE;
					end else if (dvalid) begin
						if (en) begin
							if (er)
								frame_err <= 1'b1;
							if (hold_full) begin
								// One byte leaves the hold-back into the packer
								pack_cnt <= pack_cnt + 2'd1;
								if (pack_cnt == 2'd3)
									data_valid <= 1'b1;
							end else begin
								hold_cnt <= hold_cnt + 3'd1;
							end
						end else begin
							// End of frame, flush any partial word
							if (pack_cnt != 2'd0)
								data_valid <= 1'b1;
							state <= RX_CHECK;
						end
					end
				end

				// Verdict on the next byte time
				RX_CHECK: begin
					if (!link_up) begin
						drop  <= 1'b1;
						state <= RX_IDLE;
					end else if (dvalid) begin
						if (crc_ok && hold_full && !frame_err)
							commit <= 1'b1;
						else
							drop <= 1'b1;
						state <= RX_IDLE;
					end
				end

				// Ignore everything until the carrier goes away
				RX_DROP: begin
					if (dvalid && !en)
						state <= RX_IDLE;
				end

				default: begin
					state <= RX_IDLE;
				end

			endcase
		end
	end

	////////////////////////////////////////
	// Hold-back, packer and output word

	always_ff @(posedge gmii_rx_clk) begin
		if (state == RX_FRAME_DATA && dvalid && link_up) begin
			if (en) begin
				hold <= {hold[23:0], data};

				if (hold_full) begin
					pack <= {pack[15:0], out_byte};

					// Fourth byte completes a word, oldest byte on top
					if (pack_cnt == 2'd3) begin
						word_data   <= {pack, out_byte};
						bytes_valid <= 3'd4;
					end
				end
			end else if (pack_cnt != 2'd0) begin
				// Partial word, left aligned and zero filled
				case (pack_cnt)
					2'd1:    word_data <= {pack[7:0], 24'h0};
					2'd2:    word_data <= {pack[15:0], 16'h0};
					default: word_data <= {pack, 8'h0};
				endcase
				bytes_valid <= {1'b0, pack_cnt};
			end
		end
	end

endmodule

//--- design/mac_rx_counters.sv
`timescale 1ns/100ps

module mac_rx_counters #(
	parameter int COUNTER_WIDTH = 32
) (
	input  logic                     gmii_rx_clk,
	input  logic                     arst_n,

	// Frame end pulses from the framer
	input  logic                     commit,
	input  logic                     drop,

	// Statistics
	output logic [COUNTER_WIDTH-1:0] rx_frames,
	output logic [COUNTER_WIDTH-1:0] rx_crc_err
);

	////////////////////////////////////////
	// Good frames

	// Wraps at full width
	always_ff @(posedge gmii_rx_clk or negedge arst_n) begin
		if (!arst_n) begin
			rx_frames <= '0;
		end else if (commit) begin
			rx_frames <= rx_frames + COUNTER_WIDTH'(1);
		end
	end

	////////////////////////////////////////
	// Dropped frames

	// Any drop after start counts here
	// bad FCS, er in the body, short frame or lost link
	always_ff @(posedge gmii_rx_clk or negedge arst_n) begin
		if (!arst_n) begin
			rx_crc_err <= '0;
		end else if (drop) begin
			rx_crc_err <= rx_crc_err + COUNTER_WIDTH'(1);
		end
	end

endmodule

//--- design/eth_mac_rx.sv
`timescale 1ns/100ps

module eth_mac_rx import eth_mac_pkg::*; #(
	parameter int COUNTER_WIDTH = 32
) (
	input  logic                     gmii_rx_clk,
	input  logic                     arst_n,

	// GMII receive bus
	input  logic                     dvalid,
	input  logic                     en,
	input  logic                     er,
	input  gmii_byte_t               data,

	// Link status, same clock domain
	input  logic                     link_up,

	// Upper layer frame interface
	output logic                     start,
	output logic                     data_valid,
	output logic [31:0]              word_data,
	output bytes_valid_t             bytes_valid,
	output logic                     commit,
	output logic                     drop,

	// Statistics
	output logic [COUNTER_WIDTH-1:0] rx_frames,
	output logic [COUNTER_WIDTH-1:0] rx_crc_err
);

	////////////////////////////////////////
	// Internal wiring

	// Framer to CRC engine and back
	logic        crc_restart;
	logic        crc_update;
	gmii_byte_t  crc_din;
	logic [31:0] crc;

	////////////////////////////////////////
	// Framer

	gmii_rx_framer i_gmii_rx_framer (
		.gmii_rx_clk (gmii_rx_clk),
		.arst_n      (arst_n),
		.dvalid      (dvalid),
		.en          (en),
		.er          (er),
		.data        (data),
		.link_up     (link_up),
		.crc         (crc),
		.crc_restart (crc_restart),
		.crc_update  (crc_update),
		.crc_din     (crc_din),
		.start       (start),
		.data_valid  (data_valid),
		.word_data   (word_data),
		.bytes_valid (bytes_valid),
		.commit      (commit),
		.drop        (drop)
	);

	////////////////////////////////////////
	// CRC-32, one byte per update

	crc32_eth i_crc32_eth (
		.gmii_rx_clk (gmii_rx_clk),
		.arst_n      (arst_n),
		.crc_restart (crc_restart),
		.crc_update  (crc_update),
		.din         (crc_din),
		.crc         (crc)
	);

	////////////////////////////////////////
	// Frame counters, fed by the framer's own end pulses

	mac_rx_counters #(
		.COUNTER_WIDTH (COUNTER_WIDTH)
	) i_mac_rx_counters (
		.gmii_rx_clk (gmii_rx_clk),
		.arst_n      (arst_n),
		.commit      (commit),
		.drop        (drop),
		.rx_frames   (rx_frames),
		.rx_crc_err  (rx_crc_err)
	);

endmodule

//--- tb/rx_frame_model.svh
`ifndef RX_FRAME_MODEL_SVH
`define RX_FRAME_MODEL_SVH

////////////////////////////////////////
// Model state

// Frame bytes after the SFD, payload then FCS
logic [7:0]  body_q[$];

// Expected upper layer traffic, oldest first
logic [31:0] exp_word[$];
logic [2:0]  exp_bv[$];
// 0 for commit, 1 for drop
logic        exp_end[$];

// start is due on this sample
logic        start_due;

int          errors;
int          checks;
int          n_commit;
int          n_drop;

////////////////////////////////////////
// Reference CRC-32

// Bit serial, reflected, preset to ones, inverted at the end
function automatic logic [31:0] crc32_ref(input int n);
	logic [31:0] c;
	logic        fb;
	c = 32'hffffffff;
	for (int i = 0; i < n; i++) begin
		for (int j = 0; j < 8; j++) begin
			fb = c[0] ^ body_q[i][j];
			c = c >> 1;
			if (fb)
				c = c ^ 32'hedb88320;
		end
	end
	return ~c;
endfunction

////////////////////////////////////////
// Expected traffic

// Big endian words from the first n body bytes
// last word left aligned with zero fill
task automatic queue_words(input int n);
	logic [31:0] w;
	int          k;
	for (int i = 0; i < n; i += 4) begin
		w = '0;
		k = (n - i < 4) ? n - i : 4;
		for (int j = 0; j < k; j++)
			w[31 - 8 * j -: 8] = body_q[i + j];
		exp_word.push_back(w);
		exp_bv.push_back(3'(k));
	end
endtask

// Closing pulse of an announced frame
task automatic expect_end(input logic bad);
	exp_end.push_back(bad);
	if (bad)
		n_drop++;
	else
		n_commit++;
endtask

////////////////////////////////////////
// Output monitor

// Runs on the falling edge, outputs settled since the rising edge
task automatic check_outputs();
	logic [31:0] w;
	logic [2:0]  bv;
	logic        e;
	checks++;
	assert (start == start_due) else begin
		$display("mismatch at %0t: start got %b expected %b", $time, start, start_due);
		errors++;
	end
	if (data_valid) begin
		checks++;
		assert (exp_word.size() > 0) else begin
			$display("data_valid pulsed at %0t with no word left in the model", $time);
			errors++;
		end
		if (exp_word.size() > 0) begin
			w = exp_word.pop_front();
			bv = exp_bv.pop_front();
			checks += 2;
			assert (word_data == w) else begin
				$display("mismatch at %0t: word_data got %h expected %h", $time, word_data, w);
				errors++;
			end
			assert (bytes_valid == bv) else begin
				$display("mismatch at %0t: bytes_valid got %0d expected %0d",
					$time, bytes_valid, bv);
				errors++;
			end
		end
	end
	if (commit || drop) begin
		checks++;
		assert (exp_end.size() > 0) else begin
			$display("commit or drop pulsed at %0t with no frame open", $time);
			errors++;
		end
		if (exp_end.size() > 0) begin
			e = exp_end.pop_front();
			checks += 2;
			assert (drop == e) else begin
				$display("mismatch at %0t: drop got %b expected %b", $time, drop, e);
				errors++;
			end
			assert (commit == !e) else begin
				$display("mismatch at %0t: commit got %b expected %b", $time, commit, !e);
				errors++;
			end
		end
	end
endtask

`endif

//--- tb/tb_eth_mac_rx.sv
`timescale 1ns/100ps

module tb_eth_mac_rx;

	localparam int         COUNTER_WIDTH = 32;
	localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
	localparam logic [7:0] SFD_BYTE      = 8'hd5;

	// Worst case test: 8 preamble bytes, 84 body bytes, wait and gap
	// Ten clocks per byte at the slow rate
	localparam int NUM_TESTS          = 18;
	localparam int MAX_BYTES_PER_TEST = 110;
	localparam int TIMEOUT_CYCLES     = NUM_TESTS * MAX_BYTES_PER_TEST * 10 + 1000;

	logic                     gmii_rx_clk;
	logic                     arst_n;
	logic                     dvalid;
	logic                     en;
	logic                     er;
	logic [7:0]               data;
	logic                     link_up;
	logic                     start;
	logic                     data_valid;
	logic [31:0]              word_data;
	logic [2:0]               bytes_valid;
	logic                     commit;
	logic                     drop;
	logic [COUNTER_WIDTH-1:0] rx_frames;
	logic [COUNTER_WIDTH-1:0] rx_crc_err;

	logic [31:0] lfsr_state;
	int          cycle_cnt;
	int          test_num;
	int          err_base;
	int          bad_tests;

	`include "rx_frame_model.svh"

	eth_mac_rx #(
		.COUNTER_WIDTH (COUNTER_WIDTH)
	) i_eth_mac_rx (
		.gmii_rx_clk (gmii_rx_clk),
		.arst_n      (arst_n),
		.dvalid      (dvalid),
		.en          (en),
		.er          (er),
		.data        (data),
		.link_up     (link_up),
		.start       (start),
		.data_valid  (data_valid),
		.word_data   (word_data),
		.bytes_valid (bytes_valid),
		.commit      (commit),
		.drop        (drop),
		.rx_frames   (rx_frames),
		.rx_crc_err  (rx_crc_err)
	);

	////////////////////////////////////////
	// Clock and run limit

	always #2 gmii_rx_clk = ~gmii_rx_clk;

	always @(posedge gmii_rx_clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt == TIMEOUT_CYCLES) begin
			$display("timeout: run passed %0d cycles", TIMEOUT_CYCLES);
			$display("Something failed");
			$finish;
		end
	end

	////////////////////////////////////////
	// Random numbers

	// Galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h80200003;
		return s >> 1;
	endfunction

	// One LFSR step per bit
	function automatic int rand_bits(input int n);
		int r;
		r = 0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			r = (r << 1) | int'(lfsr_state[0]);
		end
		return r;
	endfunction

	////////////////////////////////////////
	// GMII driver

	// Check the last clock's outputs, then drive the next one
	task automatic step(input logic dv, input logic e, input logic err,
			input logic [7:0] d, input logic mark);
		@(negedge gmii_rx_clk);
		check_outputs();
		start_due = mark;
		dvalid = dv;
		en = e;
		er = err;
		data = d;
	endtask

	// One byte time, strobe on every tenth clock at 10/100 Mb/s
	task automatic byte_time(input logic slow, input logic e, input logic err,
			input logic [7:0] d, input logic mark);
		if (slow)
			repeat (9) step(1'b0, e, 1'b0, d, 1'b0);
		step(1'b1, e, err, d, mark);
	endtask

	// Idle strobes until the model has seen everything, then a random gap
	task automatic settle(input logic slow);
		int gap;
		gap = 1 + rand_bits(2);
		while (exp_word.size() != 0 || exp_end.size() != 0)
			byte_time(slow, 1'b0, 1'b0, 8'h00, 1'b0);
		repeat (gap) byte_time(slow, 1'b0, 1'b0, 8'h00, 1'b0);
	endtask

	////////////////////////////////////////
	// Frame generator

	// fault: 0 none, 1 bad first byte, 2 junk before SFD, 3 preamble cut short
	// corrupt_idx, er_idx and abort_at are body byte indexes, -1 when unused
	task automatic send_frame(input int n_pay, input logic slow, input int fault,
			input int corrupt_idx, input int er_idx, input int abort_at);
		logic [31:0] fcs;
		logic [7:0]  junk;
		int          pre_len;
		int          n_send;
		pre_len = 1 + rand_bits(3) % 7;
		body_q = {};
		for (int i = 0; i < n_pay; i++)
			body_q.push_back(8'(rand_bits(8)));
		// FCS goes out low byte first
		fcs = crc32_ref(n_pay);
		for (int i = 0; i < 4; i++)
			body_q.push_back(fcs[8 * i +: 8]);
		if (corrupt_idx >= 0)
			body_q[corrupt_idx] = body_q[corrupt_idx] ^ (8'(rand_bits(8)) | 8'h01);
		n_send = (abort_at >= 0) ? abort_at : n_pay + 4;
		junk = 8'(rand_bits(8));
		if (junk == PREAMBLE_BYTE || junk == SFD_BYTE)
			junk = 8'h00;

		// Only a frame that reaches the SFD shows up on the output
		// on abort, only words completed before the link fell
		if (fault == 0) begin
			queue_words((abort_at >= 0) ? (abort_at - 4) / 4 * 4 : n_pay);
			expect_end(corrupt_idx >= 0 || er_idx >= 0 || abort_at >= 0);
		end

		byte_time(slow, 1'b1, 1'b0, (fault == 1) ? junk : PREAMBLE_BYTE, 1'b0);
		for (int i = 1; i < pre_len; i++)
			byte_time(slow, 1'b1, 1'b0, PREAMBLE_BYTE, 1'b0);
		if (fault == 2)
			byte_time(slow, 1'b1, 1'b0, junk, 1'b0);
		if (fault != 3) begin
			byte_time(slow, 1'b1, 1'b0, SFD_BYTE, fault == 0);
			for (int i = 0; i < n_send; i++)
				byte_time(slow, 1'b1, i == er_idx, body_q[i], 1'b0);
		end
		if (abort_at >= 0) begin
			// Let the last strobe land before the link goes
			step(1'b0, 1'b0, 1'b0, 8'h00, 1'b0);
			link_up = 1'b0;
		end
		settle(slow);
		link_up = 1'b1;
	endtask

	// One report line per test
	task automatic finish_test(input string name);
		test_num++;
		if (errors == err_base) begin
			$display("test %0d %s: ok", test_num, name);
		end else begin
			$display("test %0d %s: %0d errors", test_num, name, errors - err_base);
			bad_tests++;
		end
		err_base = errors;
	endtask

	////////////////////////////////////////
	// Test sequence

	initial begin
		int n;
		gmii_rx_clk = 1'b0;
		arst_n = 1'b0;
		dvalid = 1'b0;
		en = 1'b0;
		er = 1'b0;
		data = 8'h00;
		link_up = 1'b1;
		lfsr_state = 32'd11;
		start_due = 1'b0;
		repeat (2) @(negedge gmii_rx_clk);
		arst_n = 1'b1;

		// Good frames, first two cover both byte rates
		for (int i = 0; i < 8; i++) begin
			send_frame(1 + rand_bits(7) % 80, (i < 2) ? i[0] : 1'(rand_bits(1)), 0, -1, -1, -1);
			finish_test("good frame");
		end

		// One corrupted byte, payload twice then FCS twice
		for (int i = 0; i < 4; i++) begin
			n = 1 + rand_bits(7) % 80;
			send_frame(n, 1'(rand_bits(1)), 0, (i < 2) ? rand_bits(7) % n : n + rand_bits(2),
				-1, -1);
			finish_test((i < 2) ? "bad payload byte" : "bad fcs byte");
		end

		// Preamble faults stay silent
		for (int f = 1; f <= 3; f++) begin
			send_frame(1 + rand_bits(6), 1'(rand_bits(1)), f, -1, -1, -1);
			finish_test("preamble fault");
		end

		n = 1 + rand_bits(7) % 80;
		send_frame(n, 1'(rand_bits(1)), 0, -1, rand_bits(7) % n, -1);
		finish_test("er in frame data");

		send_frame(40 + rand_bits(5), 1'(rand_bits(1)), 0, -1, -1, 8 + rand_bits(4));
		finish_test("link lost after start");

		// Statistics
		checks += 2;
		assert (rx_frames == COUNTER_WIDTH'(n_commit)) else begin
			$display("mismatch at %0t: rx_frames got %0d expected %0d", $time, rx_frames, n_commit);
			errors++;
		end
		assert (rx_crc_err == COUNTER_WIDTH'(n_drop)) else begin
			$display("mismatch at %0t: rx_crc_err got %0d expected %0d", $time, rx_crc_err, n_drop);
			errors++;
		end
		finish_test("frame counters");

		$display("tests %0d, failing tests %0d, checks %0d, errors %0d",
			test_num, bad_tests, checks, errors);
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

//--- files.f
+incdir+tb
design/eth_mac_pkg.sv
design/crc32_eth.sv
design/gmii_rx_framer.sv
design/mac_rx_counters.sv
design/eth_mac_rx.sv
tb/tb_eth_mac_rx.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the GMII receive testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

# Compile DUT and testbench into one executable
verilator --binary --timing --assert \
	--top-module tb_eth_mac_rx \
	-f files.f \
	-o tb_eth_mac_rx_sim

# Run and keep the output
./obj_dir/tb_eth_mac_rx_sim | tee "$LOG"

# Verdict from the log
if grep -q "Something failed" "$LOG"; then
	echo "simulation reported failure"
	exit 1
fi
echo "simulation finished without failure"
